//--- replay_buffer_ram.sv
`default_nettype none

module replay_buffer_ram (
  input  wire                         ce_clk,

  // Write port
  input  wire                         i_wr_en,
  input  wire replay_pkg::word_addr_t i_wr_addr,
  input  wire replay_pkg::mem_data_t  i_wr_data,

  // Read port, registered
  input  wire                         i_rd_en,
  input  wire replay_pkg::word_addr_t i_rd_addr,
  output replay_pkg::mem_data_t       o_rd_data
);

  import replay_pkg::*;

  logic [MEM_DATA_W-1:0] mem [MEM_DEPTH];   // Maps onto block RAM

  always_ff @(posedge ce_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Output holds while no read is issued, the play path relies on it
  always_ff @(posedge ce_clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];     // Old data on a same-address write
    end
  end

endmodule

`default_nettype wire

//--- replay_pkg.sv
`default_nettype none

package replay_pkg;

  // ------------------------------------------------------------------
  // Buffer geometry
  // ------------------------------------------------------------------

  localparam int MEM_ADDR_W = 10;                 // 1024-word buffer
  localparam int MEM_DATA_W = 64;                 // Stream and buffer word
  localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;
  localparam int CNT_W      = MEM_ADDR_W + 1;     // Count can reach full depth

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef logic [MEM_ADDR_W-1:0] word_addr_t;     // Buffer word address
  typedef logic [CNT_W-1:0]      word_cnt_t;      // Word count
  typedef logic [MEM_DATA_W-1:0] mem_data_t;      // One sample word
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // ------------------------------------------------------------------
  // Register map, byte addresses
  // ------------------------------------------------------------------

  localparam apb_addr_t REG_REC_BASE     = 8'h00;  // RW
  localparam apb_addr_t REG_REC_SIZE     = 8'h04;  // RW
  localparam apb_addr_t REG_REC_FULLNESS = 8'h08;  // RO
  localparam apb_addr_t REG_PLAY_BASE    = 8'h0C;  // RW
  localparam apb_addr_t REG_PLAY_SIZE    = 8'h10;  // RW
  localparam apb_addr_t REG_PKT_WORDS    = 8'h14;  // RW
  localparam apb_addr_t REG_CMD          = 8'h18;  // WO, self-clearing
  localparam apb_addr_t REG_STATUS       = 8'h1C;  // RO

  // Bit positions in REG_CMD
  localparam int CMD_REC_RESTART = 0;
  localparam int CMD_PLAY_ONCE   = 1;
  localparam int CMD_PLAY_CONT   = 2;
  localparam int CMD_STOP        = 3;

  // Playback engine states
  typedef enum logic [1:0] {
    PLAY_IDLE,      // Nothing in flight
    PLAY_RUN,       // Reading the region
    PLAY_STOPPING   // Finishing the current packet, then drain
  } play_state_t;

endpackage

`default_nettype wire

//--- replay_play.sv
`default_nettype none

module replay_play (
  input  wire                         ce_clk,
  input  wire                         i_reset,

  // Configuration and commands
  input  wire replay_pkg::word_addr_t i_play_base,
  input  wire replay_pkg::word_cnt_t  i_play_size,
  input  wire replay_pkg::word_cnt_t  i_pkt_words,
  input  wire                         i_play_once,
  input  wire                         i_play_cont,
  input  wire                         i_stop,
  output logic                        o_playing,

  // Buffer read port, data one cycle after enable
  output logic                        o_rd_en,
  output replay_pkg::word_addr_t      o_rd_addr,
  input  wire replay_pkg::mem_data_t  i_rd_data,

  // Output stream
  output replay_pkg::mem_data_t       o_out_tdata,
  output logic                        o_out_tvalid,
  output logic                        o_out_tlast,
  input  wire                         i_out_tready
);

  import replay_pkg::*;

  play_state_t state;
  logic        cont;        // Continuous mode latched at start
  logic        rd_done;     // Last read of a single pass issued
  word_cnt_t   reg_cnt;     // Words read in this region pass
  word_cnt_t   pkt_cnt;     // Words read in this packet
  word_addr_t  rd_addr;
  logic        s1_valid;    // Word sitting on the RAM output
  logic        s1_last;     // Its tlast tag
  logic        out_ready;   // Output register free or draining
  logic        start, more, drained;
  logic        reg_last, pkt_last;

  // ------------------------------------------------------------------
  // Read issue
  // ------------------------------------------------------------------

  assign start    = (i_play_once | i_play_cont) && (i_play_size != '0) && (i_pkt_words != '0);
  assign reg_last = (word_cnt_t'(reg_cnt + 1'b1) == i_play_size);
  assign pkt_last = (word_cnt_t'(pkt_cnt + 1'b1) == i_pkt_words);

  // While stopping, reads go on only to finish a started packet
  assign more = ~rd_done &&
                ((state == PLAY_RUN) || ((state == PLAY_STOPPING) && (pkt_cnt != '0)));

  assign out_ready = ~o_out_tvalid | i_out_tready;
  assign o_rd_en   = more & (~s1_valid | out_ready);   // RAM output slot frees up
  assign o_rd_addr = rd_addr;
  assign drained   = ~more & ~s1_valid & ~o_out_tvalid;
  assign o_playing = (state != PLAY_IDLE);

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      state   <= PLAY_IDLE;
      cont    <= 1'b0;
      rd_done <= 1'b0;
      reg_cnt <= '0;
      pkt_cnt <= '0;
      rd_addr <= '0;
    end else begin
      case (state)
        PLAY_IDLE: begin
          if (start) begin                              // Commands while busy are ignored
            state   <= PLAY_RUN;
            cont    <= i_play_cont;
            rd_done <= 1'b0;
            reg_cnt <= '0;
            pkt_cnt <= '0;
            rd_addr <= i_play_base;
          end
        end
        PLAY_RUN: begin
          if (i_stop)       state <= PLAY_STOPPING;
          else if (drained) state <= PLAY_IDLE;          // Single pass done
        end
        PLAY_STOPPING: if (drained) state <= PLAY_IDLE;
        default:       state <= PLAY_IDLE;
      endcase

      if (o_rd_en) begin
        if (reg_last) begin
          // Region end is also a packet end; repeat from base
          reg_cnt <= '0;
          pkt_cnt <= '0;
          rd_addr <= i_play_base;
          rd_done <= ~cont;
        end else begin
          reg_cnt <= reg_cnt + 1'b1;
          pkt_cnt <= pkt_last ? '0 : word_cnt_t'(pkt_cnt + 1'b1);
          rd_addr <= rd_addr + 1'b1;                     // Wraps modulo depth
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Output pipeline, RAM output then output register
  // ------------------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      s1_valid     <= 1'b0;
      o_out_tvalid <= 1'b0;
    end else begin
      s1_valid <= o_rd_en | (s1_valid & ~out_ready);    // Held while output stalls
      if (out_ready) o_out_tvalid <= s1_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (o_rd_en) s1_last <= reg_last | pkt_last;        // Tag travels with the read
    if (out_ready && s1_valid) begin
      o_out_tdata <= i_rd_data;
      o_out_tlast <= s1_last;
    end
  end

  // Stalled word must not change
  a_out_stable: assert property (@(posedge ce_clk) disable iff (i_reset)
    o_out_tvalid && !i_out_tready
      |=> o_out_tvalid && $stable(o_out_tdata) && $stable(o_out_tlast))
    else $error("Output changed under back-pressure");

  a_idle_quiet: assert property (@(posedge ce_clk) disable iff (i_reset)
    (state == PLAY_IDLE) |-> !o_out_tvalid)
    else $error("Output valid while idle");

endmodule

`default_nettype wire

//--- replay_record.sv
`default_nettype none

module replay_record (
  input  wire                         ce_clk,
  input  wire                         i_reset,

  // Input stream
  input  wire replay_pkg::mem_data_t  i_in_tdata,
  input  wire                         i_in_tvalid,
  output logic                        o_in_tready,

  // Configuration
  input  wire replay_pkg::word_addr_t i_rec_base,
  input  wire replay_pkg::word_cnt_t  i_rec_size,
  input  wire                         i_rec_restart,
  output replay_pkg::word_cnt_t       o_fullness,

  // Buffer write port
  output logic                        o_wr_en,
  output replay_pkg::word_addr_t      o_wr_addr,
  output replay_pkg::mem_data_t       o_wr_data
);

  import replay_pkg::*;

  logic       xfer;     // Word accepted this cycle
  word_addr_t offset;   // Offset from base for this write

  assign o_in_tready = (o_fullness < i_rec_size);   // Room left below the limit
  assign xfer        = i_in_tvalid & o_in_tready;

  // A word landing with the restart pulse is the first of the new recording
  assign offset    = i_rec_restart ? '0 : word_addr_t'(o_fullness);
  assign o_wr_en   = xfer;
  assign o_wr_addr = i_rec_base + offset;           // Wraps modulo depth
  assign o_wr_data = i_in_tdata;

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_fullness <= '0;
    end else if (i_rec_restart) begin
      o_fullness <= xfer ? word_cnt_t'(1) : '0;
    end else if (xfer) begin
      o_fullness <= o_fullness + 1'b1;
    end
  end

  // Overshoot only when the size register was lowered below the count
  a_fullness_limit: assert property (@(posedge ce_clk) disable iff (i_reset)
    (o_fullness > i_rec_size) && !$past(o_fullness > i_rec_size)
      |-> ($past(i_rec_size) > i_rec_size))
    else $error("Fullness passed record size");

endmodule

`default_nettype wire

//--- replay_regs.sv
`default_nettype none

module replay_regs (
  input  wire                        ce_clk,
  input  wire                        i_reset,

  // APB slave
  input  wire                        i_psel,
  input  wire                        i_penable,
  input  wire                        i_pwrite,
  input  wire replay_pkg::apb_addr_t i_paddr,
  input  wire replay_pkg::apb_data_t i_pwdata,
  output replay_pkg::apb_data_t      o_prdata,
  output logic                       o_pready,
  output logic                       o_pslverr,

  // Configuration to the engines
  output replay_pkg::word_addr_t     o_rec_base,
  output replay_pkg::word_cnt_t      o_rec_size,
  output replay_pkg::word_addr_t     o_play_base,
  output replay_pkg::word_cnt_t      o_play_size,
  output replay_pkg::word_cnt_t      o_pkt_words,

  // Command pulses, one cycle each
  output logic                       o_rec_restart,
  output logic                       o_play_once,
  output logic                       o_play_cont,
  output logic                       o_stop,

  // Status back from the engines
  input  wire replay_pkg::word_cnt_t i_fullness,
  input  wire                        i_playing
);

  import replay_pkg::*;

  logic access;    // Access phase of a transfer
  logic addr_ok;   // Address is in the map
  logic addr_ro;   // Address is read-only
  logic wr_en;     // Legal write, commits at this edge

  assign access    = i_psel & i_penable;
  assign o_pready  = 1'b1;                                 // No wait states
  assign o_pslverr = access & (~addr_ok | (i_pwrite & addr_ro));
  assign wr_en     = access & i_pwrite & ~o_pslverr;

  // ------------------------------------------------------------------
  // Address decode and readback
  // ------------------------------------------------------------------

  always_comb begin
    addr_ok  = 1'b1;
    addr_ro  = 1'b0;
    o_prdata = '0;
    case (i_paddr)
      REG_REC_BASE:  o_prdata = apb_data_t'(o_rec_base);
      REG_REC_SIZE:  o_prdata = apb_data_t'(o_rec_size);
      REG_REC_FULLNESS: begin
        o_prdata = apb_data_t'(i_fullness);
        addr_ro  = 1'b1;
      end
      REG_PLAY_BASE: o_prdata = apb_data_t'(o_play_base);
      REG_PLAY_SIZE: o_prdata = apb_data_t'(o_play_size);
      REG_PKT_WORDS: o_prdata = apb_data_t'(o_pkt_words);
      REG_CMD:       o_prdata = '0;                        // Pulses, nothing to read
      REG_STATUS: begin
        o_prdata = apb_data_t'(i_playing);                 // Bit 0 only
        addr_ro  = 1'b1;
      end
      default:       addr_ok = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------
  // Register file and command pulses
  // ------------------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_rec_base    <= '0;
      o_rec_size    <= '0;
      o_play_base   <= '0;
      o_play_size   <= '0;
      o_pkt_words   <= '0;
      o_rec_restart <= 1'b0;
      o_play_once   <= 1'b0;
      o_play_cont   <= 1'b0;
      o_stop        <= 1'b0;
    end else begin
      // Pulses drop unless rewritten
      o_rec_restart <= 1'b0;
      o_play_once   <= 1'b0;
      o_play_cont   <= 1'b0;
      o_stop        <= 1'b0;
      if (wr_en) begin
        case (i_paddr)
          REG_REC_BASE:  o_rec_base  <= word_addr_t'(i_pwdata);  // Upper bits dropped
          REG_REC_SIZE:  o_rec_size  <= word_cnt_t'(i_pwdata);
          REG_PLAY_BASE: o_play_base <= word_addr_t'(i_pwdata);
          REG_PLAY_SIZE: o_play_size <= word_cnt_t'(i_pwdata);
          REG_PKT_WORDS: o_pkt_words <= word_cnt_t'(i_pwdata);
          REG_CMD: begin
            o_rec_restart <= i_pwdata[CMD_REC_RESTART];
            o_play_once   <= i_pwdata[CMD_PLAY_ONCE];
            o_play_cont   <= i_pwdata[CMD_PLAY_CONT];
            o_stop        <= i_pwdata[CMD_STOP];
          end
          default: ;
        endcase
      end
    end
  end

  // Access phase must follow a setup cycle
  a_apb_setup: assert property (@(posedge ce_clk) disable iff (i_reset)
    $rose(i_penable) |-> $past(i_psel & ~i_penable))
    else $error("APB enable without setup phase");

endmodule

`default_nettype wire

//--- replay_tb.sv
`default_nettype none

module replay_tb;

  import replay_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int TOTAL_WORDS     = 50 + 40 + 110 + 30 + 30;   // Words over all tests
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20;

  logic      clk;
  logic      i_reset;
  logic      i_psel, i_penable, i_pwrite;
  apb_addr_t i_paddr;
  apb_data_t i_pwdata;
  apb_data_t o_prdata;
  logic      o_pready, o_pslverr;
  mem_data_t i_in_tdata;
  logic      i_in_tvalid, o_in_tready;
  mem_data_t o_out_tdata;
  logic      o_out_tvalid, o_out_tlast, i_out_tready;

  mem_data_t   mem_model [MEM_DEPTH];   // Buffer contents as recorded
  int          rec_base_cfg, rec_count;
  int          play_base_cfg, play_size_cfg, pkt_cfg;
  int          out_idx;                 // Output words seen in this run
  int          out_limit;               // Negative means no end expected
  logic        last_seen_tlast;
  logic        ready_random;
  logic [31:0] data_rng, ready_rng;

  tb_clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen_i (.o_clk(clk));

  replay_top dut0 (
    .ce_clk       (clk),
    .i_reset      (i_reset),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .o_prdata     (o_prdata),
    .o_pready     (o_pready),
    .o_pslverr    (o_pslverr),
    .i_in_tdata   (i_in_tdata),
    .i_in_tvalid  (i_in_tvalid),
    .o_in_tready  (o_in_tready),
    .o_out_tdata  (o_out_tdata),
    .o_out_tvalid (o_out_tvalid),
    .o_out_tlast  (o_out_tlast),
    .i_out_tready (i_out_tready)
  );

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Model word for output index k as the region repeats from base
  function automatic mem_data_t expected_word(input int k);
    int addr;
    addr = (play_base_cfg + (k % play_size_cfg)) % MEM_DEPTH;
    return mem_model[addr];
  endfunction

  // Set at a packet end or at the region end
  function automatic logic expected_last(input int k);
    int pos;
    pos = (k % play_size_cfg) + 1;
    return ((pos % pkt_cfg) == 0) || (pos == play_size_cfg);
  endfunction

  function automatic apb_data_t reg_mask(input apb_addr_t addr);
    if (addr == REG_REC_BASE || addr == REG_PLAY_BASE) return (1 << MEM_ADDR_W) - 1;
    return (1 << CNT_W) - 1;
  endfunction

  task automatic check_cond(input logic ok, input string msg);
    assert (ok) else begin
      $display("ERR %0t: %s", $time, msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first failed check");
    end
  endtask

  // Setup phase then access phase with the response sampled mid access
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    @(posedge clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= wr;
    i_paddr   <= addr;
    i_pwdata  <= wdata;
    @(posedge clk);
    i_penable <= 1'b1;
    @(negedge clk);
    rdata = o_prdata;
    err   = o_pslverr;
    check_cond(o_pready === 1'b1, "APB ready low in access phase");
    @(posedge clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    logic      err;
    apb_access(1'b1, addr, data, unused, err);
    check_cond(err === 1'b0, $sformatf("slave error on write to %h", addr));
  endtask

  task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_cond(err === 1'b0, $sformatf("slave error on read of %h", addr));
  endtask

  // Offer each word on the input stream for at most max_wait cycles
  task automatic send_words(input int count, input int max_wait, output int accepted);
    mem_data_t word;
    int        i, waited;
    logic      taken;
    accepted = 0;
    @(posedge clk);
    for (i = 0; i < count; i++) begin
      data_rng = lcg_next(data_rng);
      word[63:32] = data_rng;
      data_rng = lcg_next(data_rng);
      word[31:0] = data_rng;
      if (data_rng[20]) begin                  // Occasional idle gap
        i_in_tvalid <= 1'b0;
        @(posedge clk);
      end
      i_in_tdata  <= word;
      i_in_tvalid <= 1'b1;
      waited = 0;
      taken  = 1'b0;
      while (!taken && waited < max_wait) begin
        @(negedge clk);
        if (o_in_tready) begin                 // Transfers at the coming edge
          mem_model[(rec_base_cfg + rec_count) % MEM_DEPTH] = word;
          rec_count++;
          accepted++;
          taken = 1'b1;
        end
        @(posedge clk);
        waited++;
      end
    end
    i_in_tvalid <= 1'b0;
  endtask

  task automatic wait_outputs(input int n);
    while (out_idx < n) @(posedge clk);
  endtask

  task automatic wait_until_idle();
    apb_data_t status;
    int        polls;
    polls = 0;
    read_reg(REG_STATUS, status);
    while (status[0] && polls < 40) begin
      read_reg(REG_STATUS, status);
      polls++;
    end
    check_cond(status[0] === 1'b0, "playback is still running long after its end");
  endtask

  // ------------------------------------------------------------------
  // Output back-pressure, compare and watchdog
  // ------------------------------------------------------------------

  always @(posedge clk) begin
    if (ready_random) begin
      ready_rng = lcg_next(ready_rng);
      i_out_tready <= (ready_rng[17:16] != 2'b00);    // Ready about 3 of 4 cycles
    end else begin
      i_out_tready <= 1'b1;
    end
  end

  always @(negedge clk) begin
    if (!i_reset && o_out_tvalid && i_out_tready) begin
      if (out_limit >= 0)
        check_cond(out_idx < out_limit, $sformatf("extra output word %0d", out_idx));
      check_cond(o_out_tdata === expected_word(out_idx),
                 $sformatf("word %0d data %h, expected %h", out_idx, o_out_tdata,
                           expected_word(out_idx)));
      check_cond(o_out_tlast === expected_last(out_idx),
                 $sformatf("word %0d tlast %b, expected %b", out_idx, o_out_tlast,
                           expected_last(out_idx)));
      last_seen_tlast = o_out_tlast;
      out_idx++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------

  initial begin
    apb_addr_t rw_addrs [5];
    apb_data_t rw_exp [5];
    apb_data_t rd;
    logic      err;
    int        acc, j, stop_idx;

    i_reset = 1'b1;
    i_psel = 1'b0;
    i_penable = 1'b0;
    i_pwrite = 1'b0;
    i_paddr = '0;
    i_pwdata = '0;
    i_in_tdata = '0;
    i_in_tvalid = 1'b0;
    i_out_tready = 1'b0;
    ready_random = 1'b0;
    data_rng = 32'd41;
    ready_rng = 32'd41;
    out_idx = 0;
    out_limit = 0;
    last_seen_tlast = 1'b0;
    rec_base_cfg = 0;
    rec_count = 0;
    play_base_cfg = 0;
    play_size_cfg = 1;
    pkt_cfg = 1;
    rw_addrs = '{REG_REC_BASE, REG_REC_SIZE, REG_PLAY_BASE, REG_PLAY_SIZE, REG_PKT_WORDS};

    repeat (5) @(posedge clk);
    i_reset <= 1'b0;
    @(negedge clk);
    check_cond(!o_out_tvalid && !o_in_tready, "stream valid or ready high after reset");
    read_reg(REG_STATUS, rd);
    check_cond(rd === 32'd0, $sformatf("STATUS %h after reset", rd));

    // Register readback and illegal accesses that must change nothing
    for (j = 0; j < 5; j++) begin
      data_rng = lcg_next(data_rng);
      rw_exp[j] = data_rng & reg_mask(rw_addrs[j]);
      write_reg(rw_addrs[j], rw_exp[j]);
    end
    for (j = 0; j < 5; j++) begin
      read_reg(rw_addrs[j], rd);
      check_cond(rd === rw_exp[j], $sformatf("reg %h read %h, expected %h",
                                             rw_addrs[j], rd, rw_exp[j]));
    end
    apb_access(1'b0, 8'h20, '0, rd, err);
    check_cond(err === 1'b1, "no slave error on unmapped read");
    apb_access(1'b1, 8'h20, 32'hffff_ffff, rd, err);
    check_cond(err === 1'b1, "no slave error on unmapped write");
    apb_access(1'b1, REG_STATUS, 32'hffff_ffff, rd, err);
    check_cond(err === 1'b1, "no slave error on STATUS write");
    for (j = 0; j < 5; j++) begin
      read_reg(rw_addrs[j], rd);
      check_cond(rd === rw_exp[j], $sformatf("reg %h changed to %h", rw_addrs[j], rd));
    end
    read_reg(REG_STATUS, rd);
    check_cond(rd === 32'd0, $sformatf("STATUS %h after illegal write", rd));

    // Record 50 offered words into a 40-word limit
    write_reg(REG_REC_BASE, 48);
    write_reg(REG_REC_SIZE, 40);
    write_reg(REG_CMD, 1 << CMD_REC_RESTART);
    rec_base_cfg = 48;
    rec_count = 0;
    send_words(50, 8, acc);
    check_cond(acc == 40, $sformatf("%0d words accepted, expected 40", acc));
    @(negedge clk);
    check_cond(o_in_tready === 1'b0, "input ready high at the record limit");
    read_reg(REG_REC_FULLNESS, rd);
    check_cond(rd === 32'd40, $sformatf("fullness %0d, expected 40", rd));

    // Play once with back-pressure
    write_reg(REG_PLAY_BASE, 48);
    write_reg(REG_PLAY_SIZE, 40);
    write_reg(REG_PKT_WORDS, 7);
    play_base_cfg = 48;
    play_size_cfg = 40;
    pkt_cfg = 7;
    out_idx = 0;
    out_limit = 40;
    ready_random <= 1'b1;
    write_reg(REG_CMD, 1 << CMD_PLAY_ONCE);
    read_reg(REG_STATUS, rd);
    check_cond(rd[0] === 1'b1, "STATUS not playing after play command");
    wait_outputs(40);
    wait_until_idle();
    repeat (20) @(posedge clk);                       // Room for a stray extra word

    // Continuous play across repeats until a stop
    write_reg(REG_PKT_WORDS, 6);
    pkt_cfg = 6;
    out_idx = 0;
    out_limit = -1;
    write_reg(REG_CMD, 1 << CMD_PLAY_CONT);
    wait_outputs(50);
    write_reg(REG_CMD, 1 << CMD_PLAY_ONCE);           // Ignored while playing
    wait_outputs(95);
    write_reg(REG_CMD, 1 << CMD_STOP);
    wait_until_idle();
    check_cond(last_seen_tlast === 1'b1, "last word after stop lacks tlast");
    stop_idx = out_idx;
    repeat (20) @(posedge clk);
    check_cond(out_idx == stop_idx, "output continued after stop");

    // Wrapped recording near the top of memory
    write_reg(REG_REC_BASE, 1000);
    write_reg(REG_REC_SIZE, 30);
    write_reg(REG_CMD, 1 << CMD_REC_RESTART);
    rec_base_cfg = 1000;
    rec_count = 0;
    read_reg(REG_REC_FULLNESS, rd);
    check_cond(rd === 32'd0, $sformatf("fullness %0d after restart", rd));
    send_words(30, 8, acc);
    check_cond(acc == 30, $sformatf("%0d words accepted, expected 30", acc));
    read_reg(REG_REC_FULLNESS, rd);
    check_cond(rd === 32'd30, $sformatf("fullness %0d, expected 30", rd));
    write_reg(REG_PLAY_BASE, 1000);
    write_reg(REG_PLAY_SIZE, 30);
    write_reg(REG_PKT_WORDS, 7);
    play_base_cfg = 1000;
    play_size_cfg = 30;
    pkt_cfg = 7;
    out_idx = 0;
    out_limit = 30;
    write_reg(REG_CMD, 1 << CMD_PLAY_ONCE);
    wait_outputs(30);
    wait_until_idle();
    repeat (10) @(posedge clk);                       // Room for a stray extra word

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- replay_top.f
replay_pkg.sv
replay_regs.sv
replay_record.sv
replay_play.sv
replay_buffer_ram.sv
replay_top.sv
tb_clock_gen.sv
replay_tb.sv

//--- replay_top.sv
`default_nettype none

module replay_top (
  input  wire                         ce_clk,
  input  wire                         i_reset,

  // APB control port
  input  wire                         i_psel,
  input  wire                         i_penable,
  input  wire                         i_pwrite,
  input  wire replay_pkg::apb_addr_t  i_paddr,
  input  wire replay_pkg::apb_data_t  i_pwdata,
  output replay_pkg::apb_data_t       o_prdata,
  output logic                        o_pready,
  output logic                        o_pslverr,

  // Input stream
  input  wire replay_pkg::mem_data_t  i_in_tdata,
  input  wire                         i_in_tvalid,
  output logic                        o_in_tready,

  // Output stream
  output replay_pkg::mem_data_t       o_out_tdata,
  output logic                        o_out_tvalid,
  output logic                        o_out_tlast,
  input  wire                         i_out_tready
);

  import replay_pkg::*;

  // ------------------------------------------------------------------
  // Internal connections
  // ------------------------------------------------------------------

  word_addr_t rec_base, play_base;
  word_cnt_t  rec_size, play_size, pkt_words;
  word_cnt_t  fullness;
  logic       rec_restart, play_once, play_cont, stop;
  logic       playing;

  logic       wr_en, rd_en;
  word_addr_t wr_addr, rd_addr;
  mem_data_t  wr_data, rd_data;

  replay_regs replay_regs_i (
    .ce_clk        (ce_clk),
    .i_reset       (i_reset),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .o_prdata      (o_prdata),
    .o_pready      (o_pready),
    .o_pslverr     (o_pslverr),
    .o_rec_base    (rec_base),
    .o_rec_size    (rec_size),
    .o_play_base   (play_base),
    .o_play_size   (play_size),
    .o_pkt_words   (pkt_words),
    .o_rec_restart (rec_restart),
    .o_play_once   (play_once),
    .o_play_cont   (play_cont),
    .o_stop        (stop),
    .i_fullness    (fullness),
    .i_playing     (playing)
  );

  // Record path, input stream into the buffer
  replay_record replay_record_i (
    .ce_clk        (ce_clk),
    .i_reset       (i_reset),
    .i_in_tdata    (i_in_tdata),
    .i_in_tvalid   (i_in_tvalid),
    .o_in_tready   (o_in_tready),
    .i_rec_base    (rec_base),
    .i_rec_size    (rec_size),
    .i_rec_restart (rec_restart),
    .o_fullness    (fullness),
    .o_wr_en       (wr_en),
    .o_wr_addr     (wr_addr),
    .o_wr_data     (wr_data)
  );

  // Play path, buffer out to the output stream
  replay_play replay_play_i (
    .ce_clk        (ce_clk),
    .i_reset       (i_reset),
    .i_play_base   (play_base),
    .i_play_size   (play_size),
    .i_pkt_words   (pkt_words),
    .i_play_once   (play_once),
    .i_play_cont   (play_cont),
    .i_stop        (stop),
    .o_playing     (playing),
    .o_rd_en       (rd_en),
    .o_rd_addr     (rd_addr),
    .i_rd_data     (rd_data),
    .o_out_tdata   (o_out_tdata),
    .o_out_tvalid  (o_out_tvalid),
    .o_out_tlast   (o_out_tlast),
    .i_out_tready  (i_out_tready)
  );

  replay_buffer_ram replay_buffer_ram_i (
    .ce_clk        (ce_clk),
    .i_wr_en       (wr_en),
    .i_wr_addr     (wr_addr),
    .i_wr_data     (wr_data),
    .i_rd_en       (rd_en),
    .i_rd_addr     (rd_addr),
    .o_rd_data     (rd_data)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 100              // Clock period in time units
) (
  output logic o_clk
);

  // Free-running clock, starts low
  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD / 2) o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire
